//--- hdl/pkt_chk_pkg.sv
// Sizes, vector types and packed structs for the stream checker datapath.
package pkt_chk_pkg;

    localparam int NUM_PORTS  = 2;
    localparam int DATA_BYTES = 4;
    localparam int MTU_BYTES  = 1500;

    // Galois feedback mask of the payload pattern.
    localparam logic [7:0] LFSR_MASK = 8'hB8;

    typedef logic [DATA_BYTES*8-1:0]         data_t;
    typedef logic [DATA_BYTES-1:0]           keep_t;
    typedef logic [$clog2(MTU_BYTES+1)-1:0]  byte_cnt_t;
    typedef logic [15:0]                     pkt_cnt_t;
    typedef logic [3:0]                      dest_t;
    typedef logic [7:0]                      lfsr_t;
    typedef logic [7:0]                      stall_t;

    // One stream beat without its valid/ready handshake.
    typedef struct packed {
        data_t tdata;
        keep_t tkeep;
        logic  tlast;
        dest_t tdest;
    } axis_beat_t;

    typedef struct packed {
        lfsr_t     seed;
        dest_t     dest;
        byte_cnt_t len;
        pkt_cnt_t  exp_pkts;
    } port_cfg_t;

    typedef struct packed {
        pkt_cnt_t rx_pkts;
        pkt_cnt_t err_pkts;
    } port_stat_t;

endpackage

//--- hdl/axil_pkg.sv
// AXI4-Lite channel structs and the register address map of the checker.
package axil_pkg;

    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;

    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        logic       rvalid;
    } axil_rsp_t;

    // Global registers.
    localparam axil_addr_t REG_CTRL = 8'h00;
    localparam axil_addr_t REG_DONE = 8'h04;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;
    localparam int CTRL_STALL_LSB  = 8;

    // Per-port register window.
    localparam axil_addr_t PORT_BASE   = 8'h10;
    localparam axil_addr_t PORT_STRIDE = 8'h10;
    localparam axil_addr_t OFS_CFG     = 8'h0;
    localparam axil_addr_t OFS_EXP     = 8'h4;
    localparam axil_addr_t OFS_RX      = 8'h8;
    localparam axil_addr_t OFS_ERR     = 8'hC;

    localparam int CFG_SEED_LSB = 0;
    localparam int CFG_DEST_LSB = 8;
    localparam int CFG_LEN_LSB  = 16;

endpackage

//--- hdl/pkt_payload_gen.sv
// Expected payload generator, an 8-bit LFSR unrolled over one beat.
`timescale 1ns/1ps

module pkt_payload_gen
    import pkt_chk_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  lfsr_t seed,
    input  logic  restart,
    input  logic  advance,
    input  keep_t keep,
    output data_t exp_bytes
);

    lfsr_t state;
    lfsr_t lane [DATA_BYTES+1];

    // Galois shift right.
    function automatic lfsr_t lfsr_step(lfsr_t s);
        return s[0] ? ((s >> 1) ^ LFSR_MASK) : (s >> 1);
    endfunction

    // Lane i holds the pattern i steps ahead of the current state.
    always_comb begin
        lane[0] = state;
        for (int i = 0; i < DATA_BYTES; i++) begin
            lane[i+1] = lfsr_step(lane[i]);
        end
        for (int i = 0; i < DATA_BYTES; i++) begin
            exp_bytes[8*i +: 8] = lane[i];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= '0;
        end else if (restart) begin
            state <= seed;
        end else if (advance) begin
            state <= lane[$countones(keep)];  // keep is contiguous
        end
    end

endmodule

//--- hdl/axis_packet_checker.sv
// Per-port stream checker with back-pressure, payload/length/dest checks and counters.
`timescale 1ns/1ps

module axis_packet_checker
    import pkt_chk_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  axis_beat_t beat,
    input  logic       valid,
    output logic       ready,
    input  logic       enable,
    input  logic       clear,
    input  stall_t     stall_period,
    input  port_cfg_t  cfg,
    output port_stat_t stat
);

    logic      xfer;
    stall_t    run_cnt;
    byte_cnt_t byte_cnt;
    byte_cnt_t byte_total;
    logic      pkt_err_q;
    logic      data_err;
    logic      len_err;
    logic      beat_err;
    logic      restart;
    data_t     exp_bytes;
    pkt_cnt_t  rx_cnt;
    pkt_cnt_t  err_cnt;

    assign xfer = valid && ready;

    // Ready is dropped for one cycle after stall_period cycles high.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready   <= 1'b0;
            run_cnt <= '0;
        end else if (!enable) begin
            ready   <= 1'b0;
            run_cnt <= '0;
        end else if (stall_period == '0) begin
            ready   <= 1'b1;
            run_cnt <= '0;
        end else if (ready && run_cnt >= stall_period - 8'd1) begin
            ready   <= 1'b0;
            run_cnt <= '0;
        end else begin
            ready <= 1'b1;
            if (ready) begin
                run_cnt <= run_cnt + 8'd1;
            end
        end
    end

    // Reload the pattern between packets and right after tlast.
    assign restart = clear || (xfer && beat.tlast) || (byte_cnt == '0 && !xfer);

    pkt_payload_gen u_gen (
        .clk       (clk),
        .arst_n    (arst_n),
        .seed      (cfg.seed),
        .restart   (restart),
        .advance   (xfer),
        .keep      (beat.tkeep),
        .exp_bytes (exp_bytes)
    );

    always_comb begin
        data_err = 1'b0;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (beat.tkeep[i] && beat.tdata[8*i +: 8] != exp_bytes[8*i +: 8]) begin
                data_err = 1'b1;
            end
        end
    end

    assign byte_total = byte_cnt + byte_cnt_t'($countones(beat.tkeep));
    // Overrun before tlast, or wrong total at tlast.
    assign len_err  = (byte_total > cfg.len) || (beat.tlast && byte_total != cfg.len);
    assign beat_err = data_err || len_err || (beat.tdest != cfg.dest);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            byte_cnt  <= '0;
            pkt_err_q <= 1'b0;
            rx_cnt    <= '0;
            err_cnt   <= '0;
        end else if (clear) begin
            byte_cnt  <= '0;
            pkt_err_q <= 1'b0;
            rx_cnt    <= '0;
            err_cnt   <= '0;
        end else if (xfer) begin
            if (beat.tlast) begin
                byte_cnt  <= '0;
                pkt_err_q <= 1'b0;
                rx_cnt    <= rx_cnt + 16'd1;
                if (pkt_err_q || beat_err) begin
                    err_cnt <= err_cnt + 16'd1;
                end
            end else begin
                byte_cnt  <= byte_total;
                pkt_err_q <= pkt_err_q || beat_err;
            end
        end
    end

    assign stat = '{rx_pkts: rx_cnt, err_pkts: err_cnt};

    // Sender side obligations on the keep pattern.
    a_keep_contiguous: assert property (@(posedge clk) disable iff (!arst_n)
        xfer |-> beat.tkeep[0] && ((beat.tkeep & (beat.tkeep + 1'b1)) == '0));

    a_keep_full_mid_pkt: assert property (@(posedge clk) disable iff (!arst_n)
        xfer && !beat.tlast |-> &beat.tkeep);

endmodule

//--- hdl/pkt_chk_regs.sv
// AXI4-Lite register block: control, per-port expectations and status readback.
`timescale 1ns/1ps

module pkt_chk_regs
    import pkt_chk_pkg::*;
    import axil_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  axil_req_t  axil_req,
    output axil_rsp_t  axil_rsp,
    input  port_stat_t port_stat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] done,
    output logic       ctrl_enable,
    output logic       ctrl_clear,
    output stall_t     stall_period,
    output port_cfg_t  port_cfg [NUM_PORTS]
);

    logic       aw_hs;
    logic       ar_hs;
    logic       bvalid_q;
    logic       rvalid_q;
    axil_data_t rdata_q;
    axil_data_t rd_mux;
    axil_data_t ctrl_wr;
    axil_data_t cfg_wr [NUM_PORTS];
    axil_data_t exp_wr [NUM_PORTS];

    function automatic axil_addr_t port_addr(int p, axil_addr_t ofs);
        return PORT_BASE + axil_addr_t'(p) * PORT_STRIDE + ofs;
    endfunction

    // Replace only the bytes selected by the write strobes.
    function automatic axil_data_t merge_strb(axil_data_t old_w, axil_data_t new_w,
                                              axil_strb_t strb);
        axil_data_t res;
        res = old_w;
        for (int i = 0; i < $bits(axil_strb_t); i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic axil_data_t ctrl_word(logic en, stall_t st);
        axil_data_t w;
        w = '0;
        w[CTRL_ENABLE_BIT] = en;
        w[CTRL_STALL_LSB +: $bits(stall_t)] = st;
        return w;
    endfunction

    function automatic axil_data_t cfg_word(port_cfg_t c);
        axil_data_t w;
        w = '0;
        w[CFG_SEED_LSB +: $bits(lfsr_t)]    = c.seed;
        w[CFG_DEST_LSB +: $bits(dest_t)]    = c.dest;
        w[CFG_LEN_LSB  +: $bits(byte_cnt_t)] = c.len;
        return w;
    endfunction

    // Address and data are taken together; one write in flight at a time.
    assign aw_hs = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign ar_hs = axil_req.arvalid && !rvalid_q;

    assign ctrl_wr = merge_strb(ctrl_word(ctrl_enable, stall_period),
                                axil_req.wdata, axil_req.wstrb);

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            cfg_wr[p] = merge_strb(cfg_word(port_cfg[p]), axil_req.wdata, axil_req.wstrb);
            exp_wr[p] = merge_strb(axil_data_t'(port_cfg[p].exp_pkts),
                                   axil_req.wdata, axil_req.wstrb);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_enable  <= 1'b0;
            ctrl_clear   <= 1'b0;
            stall_period <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                port_cfg[p] <= '0;
            end
        end else begin
            ctrl_clear <= 1'b0;
            if (aw_hs && axil_req.awaddr == REG_CTRL) begin
                ctrl_enable  <= ctrl_wr[CTRL_ENABLE_BIT];
                ctrl_clear   <= ctrl_wr[CTRL_CLEAR_BIT];
                stall_period <= ctrl_wr[CTRL_STALL_LSB +: $bits(stall_t)];
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (aw_hs && axil_req.awaddr == port_addr(p, OFS_CFG)) begin
                    port_cfg[p].seed <= cfg_wr[p][CFG_SEED_LSB +: $bits(lfsr_t)];
                    port_cfg[p].dest <= cfg_wr[p][CFG_DEST_LSB +: $bits(dest_t)];
                    port_cfg[p].len  <= cfg_wr[p][CFG_LEN_LSB +: $bits(byte_cnt_t)];
                end
                if (aw_hs && axil_req.awaddr == port_addr(p, OFS_EXP)) begin
                    port_cfg[p].exp_pkts <= pkt_cnt_t'(exp_wr[p]);
                end
            end
        end
    end

    // Read decode. Unmapped addresses fall through as zero.
    always_comb begin
        rd_mux = '0;
        if (axil_req.araddr == REG_CTRL) begin
            rd_mux = ctrl_word(ctrl_enable, stall_period);
        end else if (axil_req.araddr == REG_DONE) begin
            rd_mux = axil_data_t'(done);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (axil_req.araddr == port_addr(p, OFS_CFG)) begin
                rd_mux = cfg_word(port_cfg[p]);
            end else if (axil_req.araddr == port_addr(p, OFS_EXP)) begin
                rd_mux = axil_data_t'(port_cfg[p].exp_pkts);
            end else if (axil_req.araddr == port_addr(p, OFS_RX)) begin
                rd_mux = axil_data_t'(port_stat[p].rx_pkts);
            end else if (axil_req.araddr == port_addr(p, OFS_ERR)) begin
                rd_mux = axil_data_t'(port_stat[p].err_pkts);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (aw_hs) begin
                bvalid_q <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= rd_mux;
        end
    end

    assign axil_rsp = '{
        awready: aw_hs,
        wready:  aw_hs,
        bvalid:  bvalid_q,
        arready: !rvalid_q,
        rdata:   rdata_q,
        rvalid:  rvalid_q
    };

    a_bvalid_after_write: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(bvalid_q) |-> $past(aw_hs));

    a_rdata_held: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid_q && !axil_req.rready |=> $stable(rdata_q));

endmodule

//--- hdl/axis_array_packet_checker.sv
// Top level: register block, one stream checker per port and the done flags.
`timescale 1ns/1ps

module axis_array_packet_checker
    import pkt_chk_pkg::*;
    import axil_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  axil_req_t            s_axil_req,
    output axil_rsp_t            s_axil_rsp,
    input  axis_beat_t           axis_in [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] in_valid,
    output logic [NUM_PORTS-1:0] in_ready
);

    logic                 ctrl_enable;
    logic                 ctrl_clear;
    stall_t               stall_period;
    port_cfg_t            port_cfg  [NUM_PORTS];
    port_stat_t           port_stat [NUM_PORTS];
    logic [NUM_PORTS-1:0] done;

    pkt_chk_regs u_regs (
        .clk          (clk),
        .arst_n       (arst_n),
        .axil_req     (s_axil_req),
        .axil_rsp     (s_axil_rsp),
        .port_stat    (port_stat),
        .done         (done),
        .ctrl_enable  (ctrl_enable),
        .ctrl_clear   (ctrl_clear),
        .stall_period (stall_period),
        .port_cfg     (port_cfg)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        axis_packet_checker u_checker (
            .clk          (clk),
            .arst_n       (arst_n),
            .beat         (axis_in[p]),
            .valid        (in_valid[p]),
            .ready        (in_ready[p]),
            .enable       (ctrl_enable),
            .clear        (ctrl_clear),
            .stall_period (stall_period),
            .cfg          (port_cfg[p]),
            .stat         (port_stat[p])
        );

        // A zero expectation never reports done.
        assign done[p] = (port_stat[p].rx_pkts == port_cfg[p].exp_pkts) &&
                         (port_cfg[p].exp_pkts != '0);
    end

endmodule

//--- test/tb_clk_gen.sv
// Testbench clock and reset source, 100 ns period with reset held for 8 cycles.
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Release on a falling edge, away from the DUT's sampling edge.
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- test/tb_axis_array_packet_checker.sv
// Testbench for the stream checker array: AXI4-Lite and stream drivers,
// a stimulus table, a pattern and counter model, and the checks.
`timescale 1ns/1ps

module tb_axis_array_packet_checker
    import pkt_chk_pkg::*;
    import axil_pkg::*;
();

    localparam int TIMEOUT   = 1000;
    localparam int NONE      = -1;
    localparam int LEN_OK    = 0;
    localparam int LEN_SHORT = 1;
    localparam int LEN_LONG  = 2;
    localparam int NUM_ROWS  = 22;

    typedef struct packed {
        int port;
        int len;
        int dest;
        int corrupt;
        int lerr;
        int stall;
        int err;
    } row_t;

    // Port 0 expects dest 3 and port 1 expects dest 9.
    row_t rows [NUM_ROWS] = '{
        '{0,  1, 3, NONE, LEN_OK,    0, 0},
        '{1,  1, 9, NONE, LEN_OK,    0, 0},
        '{0,  4, 3, NONE, LEN_OK,    0, 0},
        '{1,  4, 9, NONE, LEN_OK,    0, 0},
        '{0,  7, 3, NONE, LEN_OK,    0, 0},
        '{1,  7, 9, NONE, LEN_OK,    0, 0},
        '{0, 64, 3, NONE, LEN_OK,    0, 0},
        '{1, 64, 9, NONE, LEN_OK,    0, 0},
        '{0,  7, 3,    0, LEN_OK,    0, 1},
        '{1, 64, 9,   37, LEN_OK,    0, 1},
        '{0,  7, 3,    6, LEN_OK,    0, 1},
        '{1,  4, 2, NONE, LEN_OK,    0, 1},
        '{0, 12, 3, NONE, LEN_SHORT, 0, 1},
        '{0, 12, 3, NONE, LEN_OK,    0, 0},
        '{1,  7, 9, NONE, LEN_LONG,  0, 1},
        '{1,  7, 9, NONE, LEN_OK,    0, 0},
        '{0, 64, 3, NONE, LEN_OK,    1, 0},
        '{1,  7, 9,    3, LEN_OK,    1, 1},
        '{0, 13, 3, NONE, LEN_OK,    3, 0},
        '{1, 64, 6, NONE, LEN_OK,    3, 1},
        '{0,  9, 3,    8, LEN_OK,    3, 1},
        '{1, 30, 9, NONE, LEN_OK,    1, 0}
    };

    logic                 clk;
    logic                 arst_n;
    axil_req_t            req;
    axil_rsp_t            rsp;
    axis_beat_t           axis_in [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;

    tb_clk_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    axis_array_packet_checker u_axis_array_packet_checker (
        .clk        (clk),
        .arst_n     (arst_n),
        .s_axil_req (req),
        .s_axil_rsp (rsp),
        .axis_in    (axis_in),
        .in_valid   (in_valid),
        .in_ready   (in_ready)
    );

    task automatic abort_run(input string what);
        $display("Verification failed");
        $fatal(1, "%s", what);
    endtask

    task automatic check_eq(input string name, input axil_data_t expected,
                            input axil_data_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    // Galois shift right, feedback mask 0xB8.
    function automatic lfsr_t lfsr_next(input lfsr_t s);
        return {1'b0, s[7:1]} ^ (s[0] ? 8'hB8 : 8'h00);
    endfunction

    function automatic axil_addr_t reg_addr(input int port, input axil_addr_t ofs);
        return axil_addr_t'(8'h10 * (port + 1)) + ofs;
    endfunction

    function automatic int port_dest(input int port);
        return (port == 0) ? 3 : 9;
    endfunction

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              input axil_strb_t strb);
        int t;
        bit hs;
        bit w_seen;
        @(negedge clk);
        req.awaddr  = addr;
        req.wdata   = data;
        req.wstrb   = strb;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        hs     = 1'b0;
        w_seen = 1'b0;
        t = 0;
        // Awready and wready are combinational and are sampled at the rising edge.
        while (!hs) begin
            @(posedge clk);
            hs     = rsp.awready;
            w_seen = rsp.wready;
            @(negedge clk);
            t++;
            if (!hs && t > TIMEOUT) begin
                abort_run("AXI4-Lite write was never accepted");
            end
        end
        check_eq("wready", 32'h1, axil_data_t'(w_seen));
        check_eq("bvalid", 32'h1, axil_data_t'(rsp.bvalid));
        // The pending response holds off a second write.
        check_eq("awready", 32'h0, axil_data_t'(rsp.awready));
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
        int t;
        bit hs;
        @(negedge clk);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        hs = 1'b0;
        t = 0;
        // Arready only changes on the rising edge.
        while (!hs) begin
            hs = rsp.arready;
            @(negedge clk);
            t++;
            if (!hs && t > TIMEOUT) begin
                abort_run("AXI4-Lite read was never accepted");
            end
        end
        check_eq("rvalid", 32'h1, axil_data_t'(rsp.rvalid));
        check_eq("arready", 32'h0, axil_data_t'(rsp.arready));
        data        = rsp.rdata;
        req.arvalid = 1'b0;
    endtask

    task automatic expect_reg(input axil_addr_t addr, input axil_data_t expected,
                              input string name);
        axil_data_t rd;
        axil_read(addr, rd);
        check_eq(name, expected, rd);
    endtask

    // With stall period N, ready is low for one cycle in every N+1.
    task automatic compare_ready_drops(input int port, input int period);
        int lows;
        lows = 0;
        for (int c = 0; c < 4 * (period + 1); c++) begin
            @(negedge clk);
            if (!in_ready[port]) begin
                lows++;
            end
        end
        check_eq($sformatf("port%0d in_ready drops", port), 32'd4, axil_data_t'(lows));
    endtask

    // Byte k carries the pattern k steps from the seed, optionally corrupted.
    task automatic send_packet(input int port, input int nbytes, input dest_t dest,
                               input lfsr_t seed, input int corrupt);
        lfsr_t      pat;
        axis_beat_t b;
        int         k;
        int         t;
        int         gap;
        bit         taken;
        pat = seed;
        k = 0;
        @(negedge clk);
        while (k < nbytes) begin
            b = '0;
            b.tdest = dest;
            for (int i = 0; i < DATA_BYTES; i++) begin
                if (k < nbytes) begin
                    b.tdata[8*i +: 8] = (k == corrupt) ? (pat ^ 8'h5A) : pat;
                    b.tkeep[i] = 1'b1;
                    pat = lfsr_next(pat);
                    k++;
                end
            end
            b.tlast = (k == nbytes);
            gap = $urandom_range(3, 0);
            if (gap > 1) begin
                in_valid[port] = 1'b0;
                repeat (gap - 1) @(negedge clk);
            end
            axis_in[port]  = b;
            in_valid[port] = 1'b1;
            taken = 1'b0;
            t = 0;
            // Ready only changes on the rising edge, so it is read here.
            while (!taken) begin
                taken = in_ready[port];
                @(negedge clk);
                t++;
                if (!taken && t > TIMEOUT) begin
                    abort_run("stream port never accepted a beat");
                end
            end
        end
        in_valid[port] = 1'b0;
    endtask

    initial begin : main
        int         exp_cnt   [NUM_PORTS];
        int         rx_model  [NUM_PORTS];
        int         err_model [NUM_PORTS];
        int         p;
        int         t;
        int         nbytes;
        lfsr_t      seed;
        axil_data_t cfg;
        axil_data_t done_exp;

        req         = '0;
        req.bready  = 1'b1;
        req.rready  = 1'b1;
        in_valid    = '0;
        for (int q = 0; q < NUM_PORTS; q++) begin
            axis_in[q]   = '0;
            exp_cnt[q]   = 0;
            rx_model[q]  = 0;
            err_model[q] = 0;
        end
        void'($urandom(32'h16932833));

        t = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) begin
                abort_run("reset was never released");
            end
        end

        // Enable is low after reset, so ready must stay low.
        for (int q = 0; q < NUM_PORTS; q++) begin
            axis_in[q] = '{tdata: 32'h0, tkeep: 4'hF, tlast: 1'b1, tdest: 4'h0};
        end
        in_valid = '1;
        repeat (10) begin
            @(negedge clk);
            check_eq("in_ready", '0, axil_data_t'(in_ready));
        end
        in_valid = '0;

        // Register readback, byte strobes and unmapped addresses.
        expect_reg(REG_CTRL, 32'h0, "CTRL after reset");
        axil_write(reg_addr(0, OFS_CFG), 32'h05DC_0AC3, 4'hF);
        expect_reg(reg_addr(0, OFS_CFG), 32'h05DC_0AC3, "port0 CFG");
        axil_write(reg_addr(1, OFS_CFG), 32'h0123_05A7, 4'hF);
        expect_reg(reg_addr(1, OFS_CFG), 32'h0123_05A7, "port1 CFG");
        axil_write(reg_addr(0, OFS_EXP), 32'h0000_1234, 4'hF);
        expect_reg(reg_addr(0, OFS_EXP), 32'h0000_1234, "port0 EXP");
        axil_write(reg_addr(0, OFS_EXP), 32'h0000_00FF, 4'b0001);
        expect_reg(reg_addr(0, OFS_EXP), 32'h0000_12FF, "port0 EXP strobed");
        axil_write(reg_addr(1, OFS_EXP), 32'h0000_BEEF, 4'hF);
        expect_reg(reg_addr(1, OFS_EXP), 32'h0000_BEEF, "port1 EXP");
        axil_write(REG_CTRL, 32'h0000_0503, 4'hF);
        expect_reg(REG_CTRL, 32'h0000_0501, "CTRL");
        expect_reg(8'h08, 32'h0, "unmapped 0x08");
        expect_reg(8'h0C, 32'h0, "unmapped 0x0C");
        expect_reg(8'h30, 32'h0, "unmapped 0x30");
        expect_reg(8'hFC, 32'h0, "unmapped 0xFC");

        for (int r = 0; r < NUM_ROWS; r++) begin
            exp_cnt[rows[r].port]++;
        end
        for (int q = 0; q < NUM_PORTS; q++) begin
            axil_write(reg_addr(q, OFS_EXP), axil_data_t'(exp_cnt[q]), 4'hF);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            p    = rows[r].port;
            seed = lfsr_t'(90 + 19 * r);
            cfg  = axil_data_t'((rows[r].len << 16) | (port_dest(p) << 8) | int'(seed));
            axil_write(REG_CTRL, axil_data_t'(1 | (rows[r].stall << 8)), 4'hF);
            axil_write(reg_addr(p, OFS_CFG), cfg, 4'hF);
            expect_reg(reg_addr(p, OFS_CFG), cfg, $sformatf("port%0d CFG", p));
            if (rows[r].stall != 0) begin
                compare_ready_drops(p, rows[r].stall);
            end

            nbytes = rows[r].len;
            if (rows[r].lerr == LEN_SHORT) begin
                nbytes = nbytes - DATA_BYTES;
            end else if (rows[r].lerr == LEN_LONG) begin
                nbytes = nbytes + DATA_BYTES;
            end
            send_packet(p, nbytes, dest_t'(rows[r].dest), seed, rows[r].corrupt);

            rx_model[p]++;
            if (rows[r].err != 0) begin
                err_model[p]++;
            end
            done_exp = '0;
            for (int q = 0; q < NUM_PORTS; q++) begin
                if (rx_model[q] == exp_cnt[q] && exp_cnt[q] != 0) begin
                    done_exp[q] = 1'b1;
                end
            end
            expect_reg(reg_addr(p, OFS_RX), axil_data_t'(rx_model[p]),
                       $sformatf("row%0d port%0d RX", r, p));
            expect_reg(reg_addr(p, OFS_ERR), axil_data_t'(err_model[p]),
                       $sformatf("row%0d port%0d ERR", r, p));
            expect_reg(REG_DONE, done_exp, $sformatf("row%0d DONE", r));
        end

        // All expectations met, then a clear empties the counters.
        expect_reg(REG_DONE, 32'h3, "DONE final");
        axil_write(REG_CTRL, 32'h0000_0303, 4'hF);
        expect_reg(REG_CTRL, 32'h0000_0301, "CTRL after clear");
        for (int q = 0; q < NUM_PORTS; q++) begin
            expect_reg(reg_addr(q, OFS_RX), 32'h0, $sformatf("port%0d RX cleared", q));
            expect_reg(reg_addr(q, OFS_ERR), 32'h0, $sformatf("port%0d ERR cleared", q));
        end
        expect_reg(REG_DONE, 32'h0, "DONE cleared");

        $display("Verification passed");
        $finish;
    end

endmodule

//--- vlog.f
hdl/pkt_chk_pkg.sv
hdl/axil_pkg.sv
hdl/pkt_payload_gen.sv
hdl/axis_packet_checker.sv
hdl/pkt_chk_regs.sv
hdl/axis_array_packet_checker.sv
test/tb_clk_gen.sv
test/tb_axis_array_packet_checker.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_axis_array_packet_checker
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulation binary exits nonzero on $fatal.
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
